// ==== hw/exec_pkg.sv ====
package exec_pkg;

  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int INST_OP_W  = 6;
  localparam int FUNCT_W    = 6;
  localparam int REGIMM_W   = 5;
  localparam int SHAMT_W    = 5;
  localparam int IMM_W      = 16;
  localparam int OPGEN_W    = 5;

  // Primary opcode field, inst[31:26]
  typedef enum logic [INST_OP_W-1:0] {
    OP_SPECIAL  = 6'b000000,
    OP_REGIMM   = 6'b000001,
    OP_J        = 6'b000010,
    OP_JAL      = 6'b000011,
    OP_BEQ      = 6'b000100,
    OP_BNE      = 6'b000101,
    OP_BLEZ     = 6'b000110,
    OP_BGTZ     = 6'b000111,
    OP_ADDI     = 6'b001000,
    OP_ADDIU    = 6'b001001,
    OP_SLTI     = 6'b001010,
    OP_SLTIU    = 6'b001011,
    OP_ANDI     = 6'b001100,
    OP_ORI      = 6'b001101,
    OP_XORI     = 6'b001110,
    OP_LUI      = 6'b001111,
    OP_CP0      = 6'b010000,
    OP_SPECIAL2 = 6'b011100,
    OP_LB       = 6'b100000,
    OP_LH       = 6'b100001,
    OP_LW       = 6'b100011,
    OP_LBU      = 6'b100100,
    OP_LHU      = 6'b100101,
    OP_SB       = 6'b101000,
    OP_SH       = 6'b101001,
    OP_SW       = 6'b101011
  } inst_op_e;

  typedef enum logic [FUNCT_W-1:0] {
    FUNCT_SLL  = 6'b000000, FUNCT_SRL   = 6'b000010, FUNCT_SRA  = 6'b000011,
    FUNCT_SLLV = 6'b000100, FUNCT_SRLV  = 6'b000110, FUNCT_SRAV = 6'b000111,
    FUNCT_JR   = 6'b001000, FUNCT_JALR  = 6'b001001, FUNCT_MOVZ = 6'b001010,
    FUNCT_MOVN = 6'b001011, FUNCT_SYSCALL = 6'b001100, FUNCT_BREAK = 6'b001101,
    FUNCT_MFHI = 6'b010000, FUNCT_MTHI  = 6'b010001, FUNCT_MFLO = 6'b010010,
    FUNCT_MTLO = 6'b010011, FUNCT_MULT  = 6'b011000, FUNCT_MULTU = 6'b011001,
    FUNCT_DIV  = 6'b011010, FUNCT_DIVU  = 6'b011011, FUNCT_ADD  = 6'b100000,
    FUNCT_ADDU = 6'b100001, FUNCT_SUB   = 6'b100010, FUNCT_SUBU = 6'b100011,
    FUNCT_AND  = 6'b100100, FUNCT_OR    = 6'b100101, FUNCT_XOR  = 6'b100110,
    FUNCT_NOR  = 6'b100111, FUNCT_SLT   = 6'b101010, FUNCT_SLTU = 6'b101011
  } funct_e;

  // rt selector under REGIMM
  typedef enum logic [REGIMM_W-1:0] {
    REGIMM_BLTZ   = 5'b00000,
    REGIMM_BGEZ   = 5'b00001,
    REGIMM_BLTZAL = 5'b10000,
    REGIMM_BGEZAL = 5'b10001
  } regimm_e;

  typedef enum logic [OPGEN_W-1:0] {
    OPGEN_NOP, OPGEN_ADD, OPGEN_SUB, OPGEN_SLT, OPGEN_SLTU,
    OPGEN_AND, OPGEN_OR, OPGEN_XOR, OPGEN_NOR,
    OPGEN_SLL, OPGEN_SRL, OPGEN_SRA, OPGEN_SLLV, OPGEN_SRLV, OPGEN_SRAV,
    OPGEN_MULT, OPGEN_MULTU, OPGEN_MFHI, OPGEN_MFLO,
    OPGEN_MTHI, OPGEN_MTLO, OPGEN_MOVZ, OPGEN_MOVN,
    OPGEN_BEQ, OPGEN_BNE, OPGEN_BGTZ, OPGEN_BLEZ, OPGEN_BLTZ, OPGEN_BGEZ
  } opgen_e;

  typedef struct packed {
    opgen_e                op;
    logic [DATA_W-1:0]     src_a;
    logic [DATA_W-1:0]     src_b;
    logic [SHAMT_W-1:0]    shamt;
    logic [REG_ADDR_W-1:0] dest;
    logic                  dest_write;
  } dec_op_t;

  typedef struct packed {
    logic [DATA_W-1:0]     result;
    logic [REG_ADDR_W-1:0] dest;
    logic                  wb_en;
    logic                  br_taken;
  } exec_res_t;

endpackage

// ==== hw/op_gen.sv ====
`timescale 1ns/10ps

module op_gen (
  input  exec_pkg::inst_op_e                 op,
  input  exec_pkg::funct_e                   funct,
  input  logic [exec_pkg::REGIMM_W-1:0]      rt,
  output exec_pkg::opgen_e                   opgen
);

  import exec_pkg::*;

  always_comb begin
    opgen = OPGEN_NOP;
    case (op)
      OP_SPECIAL: begin
        case (funct)
          FUNCT_ADD, FUNCT_ADDU: opgen = OPGEN_ADD;
          FUNCT_SUB, FUNCT_SUBU: opgen = OPGEN_SUB;
          FUNCT_SLT:   opgen = OPGEN_SLT;
          FUNCT_SLTU:  opgen = OPGEN_SLTU;
          FUNCT_AND:   opgen = OPGEN_AND;
          FUNCT_OR:    opgen = OPGEN_OR;
          FUNCT_XOR:   opgen = OPGEN_XOR;
          FUNCT_NOR:   opgen = OPGEN_NOR;
          FUNCT_SLL:   opgen = OPGEN_SLL;
          FUNCT_SRL:   opgen = OPGEN_SRL;
          FUNCT_SRA:   opgen = OPGEN_SRA;
          FUNCT_SLLV:  opgen = OPGEN_SLLV;
          FUNCT_SRLV:  opgen = OPGEN_SRLV;
          FUNCT_SRAV:  opgen = OPGEN_SRAV;
          FUNCT_MULT:  opgen = OPGEN_MULT;
          FUNCT_MULTU: opgen = OPGEN_MULTU;
          FUNCT_MFHI:  opgen = OPGEN_MFHI;
          FUNCT_MFLO:  opgen = OPGEN_MFLO;
          FUNCT_MTHI:  opgen = OPGEN_MTHI;
          FUNCT_MTLO:  opgen = OPGEN_MTLO;
          FUNCT_MOVZ:  opgen = OPGEN_MOVZ;
          FUNCT_MOVN:  opgen = OPGEN_MOVN;
          // Divide, jumps, syscall and break are not executed here
          FUNCT_DIV, FUNCT_DIVU, FUNCT_JR, FUNCT_JALR,
          FUNCT_SYSCALL, FUNCT_BREAK: opgen = OPGEN_NOP;
          default:     opgen = OPGEN_NOP;
        endcase
      end
      OP_REGIMM: begin
        // Link variants resolve like the plain compares
        case (rt)
          REGIMM_BLTZ, REGIMM_BLTZAL: opgen = OPGEN_BLTZ;
          REGIMM_BGEZ, REGIMM_BGEZAL: opgen = OPGEN_BGEZ;
          default:                    opgen = OPGEN_NOP;
        endcase
      end
      OP_ADDI, OP_ADDIU: opgen = OPGEN_ADD;
      OP_SLTI:           opgen = OPGEN_SLT;
      OP_SLTIU:          opgen = OPGEN_SLTU;
      OP_ANDI:           opgen = OPGEN_AND;
      // LUI ors the shifted immediate onto zero
      OP_LUI, OP_ORI:    opgen = OPGEN_OR;
      OP_XORI:           opgen = OPGEN_XOR;
      OP_BEQ:            opgen = OPGEN_BEQ;
      OP_BNE:            opgen = OPGEN_BNE;
      OP_BGTZ:           opgen = OPGEN_BGTZ;
      OP_BLEZ:           opgen = OPGEN_BLEZ;
      // Jumps, SPECIAL2, CP0 and memory access handled elsewhere
      OP_J, OP_JAL, OP_SPECIAL2, OP_CP0,
      OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
      OP_SB, OP_SH, OP_SW: opgen = OPGEN_NOP;
      default:             opgen = OPGEN_NOP;
    endcase
  end

endmodule

// ==== hw/inst_decoder.sv ====
`timescale 1ns/10ps

module inst_decoder (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          inst_valid,
  input  logic [exec_pkg::DATA_W-1:0]   inst,
  input  logic [exec_pkg::DATA_W-1:0]   rs_value,
  input  logic [exec_pkg::DATA_W-1:0]   rt_value,
  output logic                          dec_valid,
  output exec_pkg::dec_op_t             dec
);

  import exec_pkg::*;

  inst_op_e              opcode;
  funct_e                funct;
  logic [REG_ADDR_W-1:0] rt;
  logic [REG_ADDR_W-1:0] rd;
  logic [SHAMT_W-1:0]    sa;
  logic [IMM_W-1:0]      imm;
  opgen_e                opgen;
  dec_op_t               dec_next;

  assign opcode = inst_op_e'(inst[31:26]);
  assign rt     = inst[20:16];
  assign rd     = inst[15:11];
  assign sa     = inst[10:6];
  assign funct  = funct_e'(inst[5:0]);
  assign imm    = inst[15:0];

  op_gen op_gen_i (
    .op    (opcode),
    .funct (funct),
    .rt    (rt),
    .opgen (opgen)
  );

  always_comb begin
    dec_next       = '0;
    dec_next.op    = opgen;
    dec_next.src_a = (opcode == OP_LUI) ? '0 : rs_value;
    case (opcode)
      OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
        dec_next.src_b = {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
      OP_ANDI, OP_ORI, OP_XORI:
        dec_next.src_b = {{(DATA_W-IMM_W){1'b0}}, imm};
      OP_LUI:
        dec_next.src_b = {imm, {(DATA_W-IMM_W){1'b0}}};
      default:
        dec_next.src_b = rt_value;
    endcase
    // Variable shifts take the amount from rs
    case (opgen)
      OPGEN_SLLV, OPGEN_SRLV, OPGEN_SRAV: dec_next.shamt = rs_value[SHAMT_W-1:0];
      default:                            dec_next.shamt = sa;
    endcase
    dec_next.dest = (opcode == OP_SPECIAL) ? rd : rt;
    case (opgen)
      OPGEN_ADD, OPGEN_SUB, OPGEN_SLT, OPGEN_SLTU, OPGEN_AND, OPGEN_OR, OPGEN_XOR,
      OPGEN_NOR, OPGEN_SLL, OPGEN_SRL, OPGEN_SRA, OPGEN_SLLV, OPGEN_SRLV, OPGEN_SRAV,
      OPGEN_MFHI, OPGEN_MFLO, OPGEN_MOVZ, OPGEN_MOVN: dec_next.dest_write = 1'b1;
      default:                                        dec_next.dest_write = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec <= dec_next;
    end
  end

endmodule

// ==== hw/exec_alu.sv ====
`timescale 1ns/10ps

module exec_alu (
  input  logic                          dec_valid,
  input  exec_pkg::dec_op_t             dec,
  input  logic [exec_pkg::DATA_W-1:0]   hi,
  input  logic [exec_pkg::DATA_W-1:0]   lo,
  output exec_pkg::exec_res_t           alu_res
);

  import exec_pkg::*;

  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic [DATA_W-1:0] result;
  logic              a_zero;
  logic              a_neg;
  logic              move_blocked;
  logic              taken;

  assign a      = dec.src_a;
  assign b      = dec.src_b;
  assign a_zero = (a == '0);
  assign a_neg  = a[DATA_W-1];

  always_comb begin
    result = '0;
    case (dec.op)
      OPGEN_ADD:  result = a + b;
      OPGEN_SUB:  result = a - b;
      OPGEN_SLT:  result = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
      OPGEN_SLTU: result = {{(DATA_W-1){1'b0}}, a < b};
      OPGEN_AND:  result = a & b;
      OPGEN_OR:   result = a | b;
      OPGEN_XOR:  result = a ^ b;
      OPGEN_NOR:  result = ~(a | b);
      // Shifts always operate on rt
      OPGEN_SLL, OPGEN_SLLV: result = b << dec.shamt;
      OPGEN_SRL, OPGEN_SRLV: result = b >> dec.shamt;
      OPGEN_SRA, OPGEN_SRAV: result = $unsigned($signed(b) >>> dec.shamt);
      OPGEN_MFHI: result = hi;
      OPGEN_MFLO: result = lo;
      OPGEN_MOVZ, OPGEN_MOVN: result = a;
      default:    result = '0;
    endcase
  end

  // Conditional moves drop the write when rt fails the test
  assign move_blocked = ((dec.op == OPGEN_MOVZ) && (b != '0)) ||
                        ((dec.op == OPGEN_MOVN) && (b == '0));

  always_comb begin
    case (dec.op)
      OPGEN_BEQ:  taken = (a == b);
      OPGEN_BNE:  taken = (a != b);
      OPGEN_BGTZ: taken = !a_neg && !a_zero;
      OPGEN_BLEZ: taken = a_neg || a_zero;
      OPGEN_BLTZ: taken = a_neg;
      OPGEN_BGEZ: taken = !a_neg;
      default:    taken = 1'b0;
    endcase
  end

  always_comb begin
    alu_res.result   = result;
    alu_res.dest     = dec.dest;
    alu_res.wb_en    = dec_valid && dec.dest_write && (dec.dest != '0) && !move_blocked;
    alu_res.br_taken = dec_valid && taken;
  end

endmodule

// ==== hw/hilo_unit.sv ====
`timescale 1ns/10ps

module hilo_unit (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          dec_valid,
  input  exec_pkg::dec_op_t             dec,
  output logic [exec_pkg::DATA_W-1:0]   hi,
  output logic [exec_pkg::DATA_W-1:0]   lo
);

  import exec_pkg::*;

  logic                  is_signed;
  logic [2*DATA_W-1:0]   ext_a;
  logic [2*DATA_W-1:0]   ext_b;
  logic [2*DATA_W-1:0]   product;

  // One multiplier; sign extension picks signed or unsigned
  assign is_signed = (dec.op == OPGEN_MULT);
  assign ext_a     = {{DATA_W{is_signed & dec.src_a[DATA_W-1]}}, dec.src_a};
  assign ext_b     = {{DATA_W{is_signed & dec.src_b[DATA_W-1]}}, dec.src_b};
  assign product   = ext_a * ext_b;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hi <= '0;
      lo <= '0;
    end else if (dec_valid) begin
      case (dec.op)
        OPGEN_MULT, OPGEN_MULTU: begin
          hi <= product[2*DATA_W-1:DATA_W];
          lo <= product[DATA_W-1:0];
        end
        OPGEN_MTHI: hi <= dec.src_a;
        OPGEN_MTLO: lo <= dec.src_a;
        default: begin
          hi <= hi;
          lo <= lo;
        end
      endcase
    end
  end

endmodule

// ==== hw/result_stage.sv ====
`timescale 1ns/10ps

module result_stage (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  dec_valid,
  input  exec_pkg::exec_res_t   alu_res,
  output logic                  res_valid,
  output exec_pkg::exec_res_t   res
);

  import exec_pkg::*;

  logic [DATA_W-1:0]     result_q;
  logic [REG_ADDR_W-1:0] dest_q;
  logic                  wb_en_q;
  logic                  br_taken_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_valid  <= 1'b0;
      wb_en_q    <= 1'b0;
      br_taken_q <= 1'b0;
    end else begin
      res_valid  <= dec_valid;
      wb_en_q    <= dec_valid & alu_res.wb_en;
      br_taken_q <= dec_valid & alu_res.br_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      result_q <= alu_res.result;
      dest_q   <= alu_res.dest;
    end
  end

  assign res = '{result: result_q, dest: dest_q, wb_en: wb_en_q, br_taken: br_taken_q};

endmodule

// ==== hw/exec_top.sv ====
`timescale 1ns/10ps

module exec_top (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          inst_valid,
  input  logic [exec_pkg::DATA_W-1:0]   inst,
  input  logic [exec_pkg::DATA_W-1:0]   rs_value,
  input  logic [exec_pkg::DATA_W-1:0]   rt_value,
  output logic                          res_valid,
  output exec_pkg::exec_res_t           res
);

  import exec_pkg::*;

  logic              dec_valid;
  dec_op_t           dec;
  logic [DATA_W-1:0] hi;
  logic [DATA_W-1:0] lo;
  exec_res_t         alu_res;

  inst_decoder inst_decoder_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

  exec_alu exec_alu_i (
    .dec_valid (dec_valid),
    .dec       (dec),
    .hi        (hi),
    .lo        (lo),
    .alu_res   (alu_res)
  );

  // HI/LO commit on the same edge the result stage captures
  hilo_unit hilo_unit_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .hi        (hi),
    .lo        (lo)
  );

  result_stage result_stage_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .dec_valid (dec_valid),
    .alu_res   (alu_res),
    .res_valid (res_valid),
    .res       (res)
  );

endmodule

// ==== dv/exec_tb.sv ====
`timescale 1ns/10ps

module exec_tb;

  import exec_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int NUM_INST    = 140;
  localparam int WATCHDOG_NS = (NUM_INST * 4 + 16 + 200) * CLK_PERIOD;

  logic              clk;
  logic              arst_n;
  logic              inst_valid;
  logic [DATA_W-1:0] inst;
  logic [DATA_W-1:0] rs_value;
  logic [DATA_W-1:0] rt_value;
  logic              res_valid;
  exec_res_t         res;

  logic [31:0] lcg_state = 32'h6313;
  logic [31:0] hi_ref;
  logic [31:0] lo_ref;
  exec_res_t   exp_q[$];
  int          errors;
  int          checks;

  exec_top exec_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_value   (rs_value),
    .rt_value   (rt_value),
    .res_valid  (res_valid),
    .res        (res)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Any register except r0
  function automatic logic [4:0] rand_reg();
    return 5'(next_rand() % 31 + 1);
  endfunction

  function automatic logic [31:0] r_inst(funct_e fn, logic [4:0] rs_i, logic [4:0] rt_i,
                                         logic [4:0] rd, logic [4:0] sa);
    return {OP_SPECIAL, rs_i, rt_i, rd, sa, fn};
  endfunction

  function automatic logic [31:0] i_inst(inst_op_e op, logic [4:0] rs_i, logic [4:0] rt_i,
                                         logic [15:0] imm);
    return {op, rs_i, rt_i, imm};
  endfunction

  // Reference model in program order with its own HI/LO mirror
  task automatic predict(input logic [31:0] iw, input logic [31:0] rs, input logic [31:0] rt);
    exec_res_t   e;
    logic [31:0] sext;
    logic [31:0] zext;
    logic [63:0] prod;
    logic        wr;
    sext = {{16{iw[15]}}, iw[15:0]};
    zext = {16'h0000, iw[15:0]};
    e = '0;
    wr = 1'b0;
    e.dest = (iw[31:26] == OP_SPECIAL) ? iw[15:11] : iw[20:16];
    case (iw[31:26])
      OP_SPECIAL: begin
        wr = 1'b1;
        case (iw[5:0])
          FUNCT_ADD, FUNCT_ADDU: e.result = rs + rt;
          FUNCT_SUB, FUNCT_SUBU: e.result = rs - rt;
          FUNCT_SLT:  e.result = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
          FUNCT_SLTU: e.result = (rs < rt) ? 32'd1 : 32'd0;
          FUNCT_AND:  e.result = rs & rt;
          FUNCT_OR:   e.result = rs | rt;
          FUNCT_XOR:  e.result = rs ^ rt;
          FUNCT_NOR:  e.result = ~(rs | rt);
          FUNCT_SLL:  e.result = rt << iw[10:6];
          FUNCT_SRL:  e.result = rt >> iw[10:6];
          FUNCT_SRA:  e.result = $signed(rt) >>> iw[10:6];
          FUNCT_SLLV: e.result = rt << rs[4:0];
          FUNCT_SRLV: e.result = rt >> rs[4:0];
          FUNCT_SRAV: e.result = $signed(rt) >>> rs[4:0];
          FUNCT_MFHI: e.result = hi_ref;
          FUNCT_MFLO: e.result = lo_ref;
          FUNCT_MOVZ: begin
            e.result = rs;
            wr = (rt == 0);
          end
          FUNCT_MOVN: begin
            e.result = rs;
            wr = (rt != 0);
          end
          FUNCT_MULT, FUNCT_MULTU: begin
            if (iw[0]) begin
              prod = {32'h0, rs} * {32'h0, rt};
            end else begin
              prod = longint'($signed(rs)) * longint'($signed(rt));
            end
            {hi_ref, lo_ref} = prod;
            wr = 1'b0;
          end
          FUNCT_MTHI: begin
            hi_ref = rs;
            wr = 1'b0;
          end
          FUNCT_MTLO: begin
            lo_ref = rs;
            wr = 1'b0;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_REGIMM: begin
        case (iw[20:16])
          REGIMM_BLTZ, REGIMM_BLTZAL: e.br_taken = rs[31];
          REGIMM_BGEZ, REGIMM_BGEZAL: e.br_taken = !rs[31];
          default: e.br_taken = 1'b0;
        endcase
      end
      OP_BEQ:  e.br_taken = (rs == rt);
      OP_BNE:  e.br_taken = (rs != rt);
      OP_BLEZ: e.br_taken = ($signed(rs) <= 0);
      OP_BGTZ: e.br_taken = ($signed(rs) > 0);
      OP_ADDI, OP_ADDIU: e.result = rs + sext;
      OP_SLTI:  e.result = ($signed(rs) < $signed(sext)) ? 32'd1 : 32'd0;
      OP_SLTIU: e.result = (rs < sext) ? 32'd1 : 32'd0;
      OP_ANDI:  e.result = rs & zext;
      OP_ORI:   e.result = rs | zext;
      OP_XORI:  e.result = rs ^ zext;
      OP_LUI:   e.result = {iw[15:0], 16'h0000};
      default:  e.result = '0;
    endcase
    // Opcodes 001xxx are the immediate ALU forms
    if (iw[31:29] == 3'b001) begin
      wr = 1'b1;
    end
    e.wb_en = wr && (e.dest != 5'd0);
    exp_q.push_back(e);
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk) begin
    exec_res_t e;
    if (res_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Result strobe at %0t with no instruction outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        compare_field("res.result", res.result, e.result);
        compare_field("res.dest", 32'(res.dest), 32'(e.dest));
        compare_field("res.wb_en", 32'(res.wb_en), 32'(e.wb_en));
        compare_field("res.br_taken", 32'(res.br_taken), 32'(e.br_taken));
      end
    end else if (arst_n) begin
      // No stale flags between result strobes
      compare_field("res.wb_en", 32'(res.wb_en), 32'd0);
      compare_field("res.br_taken", 32'(res.br_taken), 32'd0);
    end
  end

  task automatic drive(input logic [31:0] iw, input logic [31:0] rs, input logic [31:0] rt);
    inst_valid <= 1'b1;
    inst       <= iw;
    rs_value   <= rs;
    rt_value   <= rt;
    predict(iw, rs, rt);
  endtask

  task automatic issue(input logic [31:0] iw, input logic [31:0] rs, input logic [31:0] rt);
    @(posedge clk);
    drive(iw, rs, rt);
  endtask

  task automatic quiet_after_reset();
    repeat (5) begin
      @(posedge clk);
      if (res_valid) begin
        errors++;
        $display("res_valid went high at %0t without any strobe", $time);
      end
    end
  endtask

  // Strobes driven at loop edges 0..n-1 must come back at edges 3..n+2
  task automatic strobe_timing(input int n);
    int seen;
    int first;
    int last;
    seen = 0;
    first = -1;
    last = -1;
    for (int k = 0; k < 10; k++) begin
      @(posedge clk);
      if (res_valid) begin
        seen++;
        if (first < 0) begin
          first = k;
        end
        last = k;
      end
      if (k < n) begin
        drive(r_inst(FUNCT_ADD, 5'd1, 5'd2, rand_reg(), 5'd0), next_rand(), next_rand());
      end else begin
        inst_valid <= 1'b0;
      end
    end
    if (seen != n || first != 3 || last != n + 2) begin
      errors++;
      $display("Expected %0d result strobes at edges 3 to %0d, saw %0d from %0d to %0d",
               n, n + 2, seen, first, last);
    end
  endtask

  task automatic arith_logic_mix();
    funct_e   fns[8] = '{FUNCT_ADD, FUNCT_SUBU, FUNCT_SLT, FUNCT_SLTU,
                         FUNCT_AND, FUNCT_OR, FUNCT_XOR, FUNCT_NOR};
    inst_op_e ops[8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                         OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
    repeat (4) begin
      foreach (fns[i]) begin
        issue(r_inst(fns[i], rand_reg(), rand_reg(), rand_reg(), 5'd0), next_rand(),
              next_rand());
      end
      foreach (ops[i]) begin
        issue(i_inst(ops[i], rand_reg(), rand_reg(), 16'(next_rand())), next_rand(),
              next_rand());
      end
    end
  endtask

  task automatic shift_mix();
    funct_e fns[6] = '{FUNCT_SLL, FUNCT_SRL, FUNCT_SRA, FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV};
    repeat (4) begin
      foreach (fns[i]) begin
        issue(r_inst(fns[i], rand_reg(), rand_reg(), rand_reg(), 5'(next_rand())),
              next_rand(), next_rand());
      end
    end
  endtask

  task automatic hilo_sequence();
    // HI and LO still hold their reset value
    issue(r_inst(FUNCT_MFHI, 5'd0, 5'd0, 5'd6, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MFLO, 5'd0, 5'd0, 5'd7, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MULT, 5'd4, 5'd5, 5'd9, 5'd0), next_rand() | 32'h8000_0000,
          next_rand());
    issue(r_inst(FUNCT_MFHI, 5'd0, 5'd0, 5'd6, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MFLO, 5'd0, 5'd0, 5'd7, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MULTU, 5'd4, 5'd5, 5'd9, 5'd0), next_rand() | 32'h8000_0000,
          next_rand());
    issue(r_inst(FUNCT_MFHI, 5'd0, 5'd0, 5'd6, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MFLO, 5'd0, 5'd0, 5'd7, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MTHI, 5'd3, 5'd0, 5'd8, 5'd0), next_rand(), '0);
    issue(r_inst(FUNCT_MTLO, 5'd3, 5'd0, 5'd8, 5'd0), next_rand(), '0);
    issue(r_inst(FUNCT_MFHI, 5'd0, 5'd0, 5'd6, 5'd0), '0, '0);
    issue(r_inst(FUNCT_MFLO, 5'd0, 5'd0, 5'd7, 5'd0), '0, '0);
  endtask

  task automatic branch_and_move();
    // Equal, greater and less pairs, then zero, positive and negative rs
    logic [31:0] av[3] = '{32'd7, 32'd7, 32'hFFFF_FFFC};
    logic [31:0] bv[3] = '{32'd7, 32'hFFFF_FFFE, 32'd9};
    logic [31:0] zv[3] = '{32'd0, 32'd12, 32'hFFFF_FFF4};
    for (int i = 0; i < 3; i++) begin
      issue(i_inst(OP_BEQ, 5'd1, 5'd2, 16'h0010), av[i], bv[i]);
      issue(i_inst(OP_BNE, 5'd1, 5'd2, 16'h0010), av[i], bv[i]);
      issue(i_inst(OP_BGTZ, 5'd1, 5'd0, 16'h0010), zv[i], '0);
      issue(i_inst(OP_BLEZ, 5'd1, 5'd0, 16'h0010), zv[i], '0);
      issue(i_inst(OP_REGIMM, 5'd1, REGIMM_BLTZ, 16'h0010), zv[i], '0);
      issue(i_inst(OP_REGIMM, 5'd1, REGIMM_BGEZ, 16'h0010), zv[i], '0);
    end
    issue(r_inst(FUNCT_MOVZ, 5'd1, 5'd2, 5'd10, 5'd0), next_rand(), '0);
    issue(r_inst(FUNCT_MOVZ, 5'd1, 5'd2, 5'd10, 5'd0), next_rand(), 32'd5);
    issue(r_inst(FUNCT_MOVN, 5'd1, 5'd2, 5'd10, 5'd0), next_rand(), '0);
    issue(r_inst(FUNCT_MOVN, 5'd1, 5'd2, 5'd10, 5'd0), next_rand(), 32'd5);
  endtask

  task automatic unsupported_and_r0();
    issue(r_inst(FUNCT_DIV, 5'd1, 5'd2, 5'd11, 5'd0), next_rand(), next_rand());
    // SPECIAL2 MUL with rd 12
    issue(i_inst(OP_SPECIAL2, 5'd1, 5'd2, 16'h6002), next_rand(), next_rand());
    issue(i_inst(OP_LW, 5'd1, 5'd13, 16'h0040), next_rand(), next_rand());
    issue(i_inst(OP_J, 5'd0, 5'd0, 16'h0100), next_rand(), next_rand());
    issue(r_inst(FUNCT_ADD, 5'd1, 5'd2, 5'd0, 5'd0), next_rand(), next_rand());
    issue(i_inst(OP_ORI, 5'd1, 5'd0, 16'h1234), next_rand(), next_rand());
  endtask

  task automatic drain();
    @(posedge clk);
    inst_valid <= 1'b0;
    for (int k = 0; k < 10 && exp_q.size() != 0; k++) begin
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results never came out of the DUT", exp_q.size());
    end
  endtask

  initial begin
    clk        = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    rs_value   = '0;
    rt_value   = '0;
    hi_ref     = '0;
    lo_ref     = '0;
    errors     = 0;
    checks     = 0;
    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    quiet_after_reset();
    strobe_timing(1);
    strobe_timing(4);
    arith_logic_mix();
    shift_mix();
    hilo_sequence();
    branch_and_move();
    unsupported_and_r0();
    drain();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d results outstanding",
             WATCHDOG_NS, exp_q.size());
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== project.f ====
hw/exec_pkg.sv
hw/op_gen.sv
hw/inst_decoder.sv
hw/exec_alu.sv
hw/hilo_unit.sv
hw/result_stage.sv
hw/exec_top.sv
dv/exec_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := exec_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
